//--- verilog/mpmem_port_pkg.sv
package mpmem_port_pkg;

  // ***********************************************************************
  // user-side sizes
  // ***********************************************************************

  parameter int DATA_W = 32;
  parameter int ADDR_W = 8;

  // every address in the space maps to one row in each bank
  parameter int NUM_ADDR = 1 << ADDR_W;

  // ***********************************************************************
  // port bundles
  // ***********************************************************************

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] din;
  } wr_req_t;

  typedef struct packed {
    logic              read;
    logic [ADDR_W-1:0] addr;
  } rd_req_t;

  // rd_dout is only meaningful in a cycle where rd_vld is high
  typedef struct packed {
    logic              rd_vld;
    logic [DATA_W-1:0] rd_dout;
  } rd_rsp_t;

endpackage

//--- verilog/mpmem_ctrl_pkg.sv
package mpmem_ctrl_pkg;

  // sequence of the power-up sweep
  typedef enum logic [1:0] {
    INIT_WAIT,
    INIT_CLEAR,
    INIT_DONE
  } init_state_t;

  // one address is cleared per cycle while the strobe is high
  typedef struct packed {
    logic                              clr;
    logic [mpmem_port_pkg::ADDR_W-1:0] addr;
  } clr_cmd_t;

endpackage

//--- verilog/mpmem_init_ctrl.sv
module mpmem_init_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  output mpmem_ctrl_pkg::clr_cmd_t clr,
  output logic                     ready
);

  // the address space is a power of two, so the sweep ends on all ones
  localparam logic [mpmem_port_pkg::ADDR_W-1:0] LAST_ADDR = '1;

  logic                              reset_q;
  logic                              rst_int;
  mpmem_ctrl_pkg::init_state_t       state;
  logic [mpmem_port_pkg::ADDR_W-1:0] clr_addr;

  // a single-cycle glitch on reset is filtered out
  always_ff @(posedge clk) begin
    reset_q <= reset;
  end

  assign rst_int = reset_q && reset;

  always_ff @(posedge clk) begin
    if (rst_int) begin
      state    <= mpmem_ctrl_pkg::INIT_WAIT;
      clr_addr <= '0;
    end else begin
      case (state)
        mpmem_ctrl_pkg::INIT_WAIT: begin
          state <= mpmem_ctrl_pkg::INIT_CLEAR;
        end
        mpmem_ctrl_pkg::INIT_CLEAR: begin
          clr_addr <= clr_addr + 1'b1;
          if (clr_addr == LAST_ADDR) begin
            state <= mpmem_ctrl_pkg::INIT_DONE;
          end
        end
        default: begin
          state <= mpmem_ctrl_pkg::INIT_DONE;
        end
      endcase
    end
  end

  assign clr.clr  = (state == mpmem_ctrl_pkg::INIT_CLEAR);
  assign clr.addr = clr_addr;
  assign ready    = (state == mpmem_ctrl_pkg::INIT_DONE);

  // once up, the memory only goes back to clearing through a qualified reset
  ready_holds: assert property (@(posedge clk) $past(ready) && !ready |-> $past(rst_int));

endmodule

//--- verilog/mpmem_sram_1r1w.sv
module mpmem_sram_1r1w #(
  parameter int SRAM_DELAY = 1
) (
  input  logic                              clk,
  input  logic                              write,
  input  logic [mpmem_port_pkg::ADDR_W-1:0] wr_addr,
  input  logic [mpmem_port_pkg::DATA_W-1:0] din,
  input  logic                              read,
  input  logic [mpmem_port_pkg::ADDR_W-1:0] rd_addr,
  output logic [mpmem_port_pkg::DATA_W-1:0] dout
);

  logic [mpmem_port_pkg::DATA_W-1:0] mem [mpmem_port_pkg::NUM_ADDR];
  logic [mpmem_port_pkg::DATA_W-1:0] rd_pipe [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_addr] <= din;
    end
  end

  // the array is sampled before this edge's write lands, so a colliding
  // read sees the old word
  always_ff @(posedge clk) begin
    if (read) begin
      rd_pipe[0] <= mem[rd_addr];
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[SRAM_DELAY-1];

  rd_addr_known: assert property (@(posedge clk) read |-> !$isunknown(rd_addr));

endmodule

//--- verilog/mpmem_lvt.sv
module mpmem_lvt #(
  parameter int NUM_RD = 2,
  parameter int NUM_WR = 4
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   ready,
  input  mpmem_ctrl_pkg::clr_cmd_t               clr,
  input  mpmem_port_pkg::wr_req_t [NUM_WR-1:0]   wr,
  input  mpmem_port_pkg::rd_req_t [NUM_RD-1:0]   rd,
  output logic [NUM_RD-1:0][(NUM_WR > 1 ? $clog2(NUM_WR) : 1)-1:0] sel
);

  localparam int SEL_W = (NUM_WR > 1) ? $clog2(NUM_WR) : 1;

  // one entry per address naming the write port that last touched it
  logic [SEL_W-1:0] lvt_mem [mpmem_port_pkg::NUM_ADDR];

  // ***********************************************************************
  // table update
  // ***********************************************************************

  // later loop passes override earlier ones, so the highest port wins a
  // same-address collision
  always_ff @(posedge clk) begin
    if (!ready) begin
      if (clr.clr) begin
        lvt_mem[clr.addr] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_WR; w++) begin
        if (wr[w].write) begin
          lvt_mem[wr[w].addr] <= SEL_W'(w);
        end
      end
    end
  end

  // ***********************************************************************
  // lookup
  // ***********************************************************************

  // the entry is read before this edge's update, matching the banks
  always_ff @(posedge clk) begin
    if (reset) begin
      sel <= '0;
    end else begin
      for (int r = 0; r < NUM_RD; r++) begin
        if (rd[r].read) begin
          sel[r] <= lvt_mem[rd[r].addr];
        end
      end
    end
  end

  // the sweep must have left a valid port index in every looked-up entry
  for (genvar r = 0; r < NUM_RD; r++) begin : g_chk
    sel_in_range: assert property (
      @(posedge clk) disable iff (reset) ready |-> !$isunknown(sel[r]) && int'(sel[r]) < NUM_WR
    );
  end

endmodule

//--- verilog/mpmem_core.sv
module mpmem_core #(
  parameter int NUM_RD     = 2,
  parameter int NUM_WR     = 4,
  parameter int SRAM_DELAY = 1
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 ready,
  input  mpmem_ctrl_pkg::clr_cmd_t             clr,
  input  mpmem_port_pkg::wr_req_t [NUM_WR-1:0] wr,
  input  mpmem_port_pkg::rd_req_t [NUM_RD-1:0] rd,
  output mpmem_port_pkg::rd_rsp_t [NUM_RD-1:0] rd_rsp
);

  localparam int SEL_W = (NUM_WR > 1) ? $clog2(NUM_WR) : 1;

  mpmem_port_pkg::wr_req_t [NUM_WR-1:0] wr_g;
  mpmem_port_pkg::rd_req_t [NUM_RD-1:0] rd_g;
  logic [NUM_RD-1:0]                    rd_stb;

  logic [NUM_WR-1:0]                    bank_we;
  logic [mpmem_port_pkg::ADDR_W-1:0]    bank_waddr [NUM_WR];
  logic [mpmem_port_pkg::DATA_W-1:0]    bank_din [NUM_WR];
  logic [mpmem_port_pkg::DATA_W-1:0]    bank_dout [NUM_WR][NUM_RD];

  logic [NUM_RD-1:0][SEL_W-1:0]         sel;
  logic [NUM_RD-1:0][SEL_W-1:0]         sel_al;
  logic [NUM_RD-1:0]                    rd_pipe [SRAM_DELAY];
  logic [NUM_RD-1:0]                    rsp_vld;
  logic [mpmem_port_pkg::DATA_W-1:0]    rsp_dout [NUM_RD];

  // user strobes are dead until the clearing sweep is over
  always_comb begin
    wr_g = wr;
    rd_g = rd;
    for (int w = 0; w < NUM_WR; w++) begin
      wr_g[w].write = wr[w].write & ready;
    end
    for (int r = 0; r < NUM_RD; r++) begin
      rd_g[r].read = rd[r].read & ready;
      rd_stb[r]    = rd_g[r].read;
    end
  end

  // during initialization every bank write port carries the clear
  always_comb begin
    for (int w = 0; w < NUM_WR; w++) begin
      if (ready) begin
        bank_we[w]    = wr_g[w].write;
        bank_waddr[w] = wr_g[w].addr;
        bank_din[w]   = wr_g[w].din;
      end else begin
        bank_we[w]    = clr.clr;
        bank_waddr[w] = clr.addr;
        bank_din[w]   = '0;
      end
    end
  end

  // ***********************************************************************
  // bank array, one bank per write port and read port pair
  // ***********************************************************************

  for (genvar w = 0; w < NUM_WR; w++) begin : g_wr
    for (genvar r = 0; r < NUM_RD; r++) begin : g_rd
      mpmem_sram_1r1w #(
        .SRAM_DELAY(SRAM_DELAY)
      ) u_bank (
        .clk    (clk),
        .write  (bank_we[w]),
        .wr_addr(bank_waddr[w]),
        .din    (bank_din[w]),
        .read   (rd_g[r].read),
        .rd_addr(rd_g[r].addr),
        .dout   (bank_dout[w][r])
      );
    end
  end

  mpmem_lvt #(
    .NUM_RD(NUM_RD),
    .NUM_WR(NUM_WR)
  ) u_lvt (
    .clk  (clk),
    .reset(reset),
    .ready(ready),
    .clr  (clr),
    .wr   (wr_g),
    .rd   (rd_g),
    .sel  (sel)
  );

  // ***********************************************************************
  // alignment and output select
  // ***********************************************************************

  // the table lookup already costs one cycle of the bank latency
  if (SRAM_DELAY == 1) begin : g_sel_now
    assign sel_al = sel;
  end else begin : g_sel_dly
    logic [NUM_RD-1:0][SEL_W-1:0] sel_dly [SRAM_DELAY-1];

    always_ff @(posedge clk) begin
      sel_dly[0] <= sel;
      for (int i = 1; i < SRAM_DELAY - 1; i++) begin
        sel_dly[i] <= sel_dly[i-1];
      end
    end

    assign sel_al = sel_dly[SRAM_DELAY-2];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < SRAM_DELAY; i++) begin
        rd_pipe[i] <= '0;
      end
      rsp_vld <= '0;
    end else begin
      rd_pipe[0] <= rd_stb;
      for (int i = 1; i < SRAM_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
      rsp_vld <= rd_pipe[SRAM_DELAY-1];
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < NUM_RD; r++) begin
      rsp_dout[r] <= bank_dout[sel_al[r]][r];
    end
  end

  always_comb begin
    for (int r = 0; r < NUM_RD; r++) begin
      rd_rsp[r].rd_vld  = rsp_vld[r];
      rd_rsp[r].rd_dout = rsp_dout[r];
    end
  end

endmodule

//--- verilog/mpmem_top.sv
module mpmem_top #(
  parameter int NUM_RD     = 2,
  parameter int NUM_WR     = 4,
  parameter int SRAM_DELAY = 1
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  mpmem_port_pkg::wr_req_t [NUM_WR-1:0] wr,
  input  mpmem_port_pkg::rd_req_t [NUM_RD-1:0] rd,
  output mpmem_port_pkg::rd_rsp_t [NUM_RD-1:0] rd_rsp,
  output logic                                 ready
);

  mpmem_ctrl_pkg::clr_cmd_t clr;

  // clears the whole address space after reset, then opens the ports
  mpmem_init_ctrl u_init (
    .clk  (clk),
    .reset(reset),
    .clr  (clr),
    .ready(ready)
  );

  mpmem_core #(
    .NUM_RD    (NUM_RD),
    .NUM_WR    (NUM_WR),
    .SRAM_DELAY(SRAM_DELAY)
  ) u_core (
    .clk   (clk),
    .reset (reset),
    .ready (ready),
    .clr   (clr),
    .wr    (wr),
    .rd    (rd),
    .rd_rsp(rd_rsp)
  );

endmodule

//--- verif/mpmem_tb.sv
module mpmem_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RD     = 2;
  localparam int NUM_WR     = 4;
  localparam int SRAM_DELAY = 1;
  localparam int NUM_ADDR   = mpmem_port_pkg::NUM_ADDR;
  localparam int ADDR_W     = mpmem_port_pkg::ADDR_W;
  localparam int RESET_CYC  = 10;
  localparam int RAND_CYC   = 300;
  // two clearing passes with their full read sweeps dominate the run
  localparam int TIMEOUT    =
    2 * (2 * (RESET_CYC + 2 * NUM_ADDR) + NUM_WR * 16 + RAND_CYC + 64);

  logic                                 clk = 1'b0;
  logic                                 reset;
  mpmem_port_pkg::wr_req_t [NUM_WR-1:0] wr;
  mpmem_port_pkg::rd_req_t [NUM_RD-1:0] rd;
  mpmem_port_pkg::rd_rsp_t [NUM_RD-1:0] rd_rsp;
  logic                                 ready;

  // requests staged for the next edge
  mpmem_port_pkg::wr_req_t [NUM_WR-1:0] wr_n;
  mpmem_port_pkg::rd_req_t [NUM_RD-1:0] rd_n;

  logic [mpmem_port_pkg::DATA_W-1:0] model [NUM_ADDR];
  logic [mpmem_port_pkg::DATA_W-1:0] exp_q [NUM_RD][$];
  int                                issue_q [NUM_RD][$];

  int cyc = 0;
  int n_tests = 0;
  int n_checks = 0;
  int n_errors = 0;
  int seed = 65;

  always #4 clk = ~clk;

  mpmem_top #(
    .NUM_RD    (NUM_RD),
    .NUM_WR    (NUM_WR),
    .SRAM_DELAY(SRAM_DELAY)
  ) u_dut (
    .clk   (clk),
    .reset (reset),
    .wr    (wr),
    .rd    (rd),
    .rd_rsp(rd_rsp),
    .ready (ready)
  );

  // ************************************************************************
  // checking
  // ************************************************************************

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  // a strobe driven at one edge is accepted at the next, so the response
  // shows up SRAM_DELAY + 2 edges after the drive
  always @(posedge clk) begin
    for (int r = 0; r < NUM_RD; r++) begin
      if (rd_rsp[r].rd_vld === 1'b1) begin
        if (exp_q[r].size() == 0) begin
          n_errors++;
          $display("read port %0d returned data with no read outstanding", r);
        end else begin
          check($sformatf("rd_rsp[%0d].rd_dout", r), rd_rsp[r].rd_dout, exp_q[r].pop_front());
          check($sformatf("rd_rsp[%0d].rd_vld latency", r), cyc - issue_q[r].pop_front(),
                SRAM_DELAY + 2);
        end
      end
    end
    cyc <= cyc + 1;
  end

  initial begin
    while (cyc < TIMEOUT) begin
      @(posedge clk);
    end
    $display("timeout: the run went past %0d cycles without finishing", TIMEOUT);
    $display("Simulation failed");
    $finish;
  end

  // ************************************************************************
  // stimulus helpers
  // ************************************************************************

  // reads see the model before this edge's writes land
  task automatic step();
    @(posedge clk);
    for (int r = 0; r < NUM_RD; r++) begin
      if (rd_n[r].read) begin
        exp_q[r].push_back(model[rd_n[r].addr]);
        issue_q[r].push_back(cyc);
      end
    end
    for (int w = 0; w < NUM_WR; w++) begin
      if (wr_n[w].write) begin
        model[wr_n[w].addr] = wr_n[w].din;
      end
    end
    wr <= wr_n;
    rd <= rd_n;
    wr_n = '0;
    rd_n = '0;
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int r = 0; r < NUM_RD; r++) begin
      n += exp_q[r].size();
    end
    return n;
  endfunction

  task automatic drain();
    step();
    while (pending() != 0) begin
      step();
    end
  endtask

  task automatic stage_read_all(input logic [ADDR_W-1:0] addr);
    for (int r = 0; r < NUM_RD; r++) begin
      rd_n[r] = '{read: 1'b1, addr: addr};
    end
  endtask

  task automatic finish_test(input string name, input int err0);
    n_tests++;
    $display("test %s finished with %0d errors", name, n_errors - err0);
  endtask

  // ************************************************************************
  // directed tests
  // ************************************************************************

  // the sweep must leave zero even where earlier traffic wrote data
  task automatic test_clear_ready();
    int err0;
    int n;
    err0 = n_errors;
    reset <= 1'b1;
    for (int a = 0; a < NUM_ADDR; a++) begin
      model[a] = '0;
    end
    repeat (RESET_CYC) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check("ready", ready, 0);
    n = 0;
    while (!ready && n <= NUM_ADDR + 8) begin
      @(posedge clk);
      n++;
    end
    check("ready delay", n, NUM_ADDR + 1);
    for (int a = 0; a < NUM_ADDR; a++) begin
      for (int r = 0; r < NUM_RD; r++) begin
        rd_n[r] = '{read: 1'b1, addr: ADDR_W'(a + r * 64)};
      end
      step();
    end
    drain();
    finish_test("clear_ready", err0);
  endtask

  task automatic test_single_port();
    int err0;
    logic [ADDR_W-1:0] addr;
    err0 = n_errors;
    for (int w = 0; w < NUM_WR; w++) begin
      for (int k = 0; k < 4; k++) begin
        addr = ADDR_W'(8 + w * 16 + k);
        wr_n[w] = '{write: 1'b1, addr: addr, din: $random(seed)};
        step();
        stage_read_all(addr);
        step();
      end
    end
    drain();
    finish_test("single_port", err0);
  endtask

  task automatic test_parallel();
    int err0;
    int n;
    logic [ADDR_W-1:0] addrs [$];
    err0 = n_errors;
    for (int rep = 0; rep < 4; rep++) begin
      for (int w = 0; w < NUM_WR; w++) begin
        addrs.push_back(ADDR_W'(8'h80 + rep * NUM_WR + w));
        wr_n[w] = '{write: 1'b1, addr: addrs[$], din: $random(seed)};
      end
      step();
    end
    n = addrs.size();
    for (int i = 0; i < n; i++) begin
      for (int r = 0; r < NUM_RD; r++) begin
        rd_n[r] = '{read: 1'b1, addr: addrs[(i + r) % n]};
      end
      step();
    end
    drain();
    finish_test("parallel", err0);
  endtask

  task automatic test_conflict();
    int err0;
    logic [ADDR_W-1:0] addr;
    err0 = n_errors;
    addr = 8'hA5;
    wr_n[0] = '{write: 1'b1, addr: addr, din: $random(seed)};
    step();
    // every port hits the same word while port 0 reads it at that edge
    for (int w = 0; w < NUM_WR; w++) begin
      wr_n[w] = '{write: 1'b1, addr: addr, din: $random(seed)};
    end
    rd_n[0] = '{read: 1'b1, addr: addr};
    step();
    stage_read_all(addr);
    step();
    drain();
    finish_test("conflict", err0);
  endtask

  task automatic test_random();
    int err0;
    err0 = n_errors;
    for (int c = 0; c < RAND_CYC; c++) begin
      for (int w = 0; w < NUM_WR; w++) begin
        if (($random(seed) & 1) == 1) begin
          wr_n[w] = '{write: 1'b1, addr: ADDR_W'(8'hC0 + ($random(seed) & 32'h1F)),
                      din: $random(seed)};
        end
      end
      for (int r = 0; r < NUM_RD; r++) begin
        rd_n[r] = '{read: 1'b1, addr: ADDR_W'(8'hC0 + ($random(seed) & 32'h1F))};
      end
      step();
    end
    drain();
    finish_test("random", err0);
  endtask

  initial begin
    reset = 1'b1;
    wr    = '0;
    rd    = '0;
    wr_n  = '0;
    rd_n  = '0;
    test_clear_ready();
    test_single_port();
    test_parallel();
    test_conflict();
    test_random();
    test_clear_ready();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- build.f
verilog/mpmem_port_pkg.sv
verilog/mpmem_ctrl_pkg.sv
verilog/mpmem_init_ctrl.sv
verilog/mpmem_sram_1r1w.sv
verilog/mpmem_lvt.sv
verilog/mpmem_core.sv
verilog/mpmem_top.sv
verif/mpmem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and scan the log for failure.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module mpmem_tb -o mpmem_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mpmem_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"
exit 0
